//--- hw/dfdd_cfg.svh
// image geometry macros
// signed fixed-point format used by the exact arithmetic
`ifndef DFDD_CFG_SVH
`define DFDD_CFG_SVH

// pixels per row, at least 3
`define DFDD_IMAGE_WIDTH 8
`define DFDD_IMAGE_HEIGHT 4
`define DFDD_POS_WIDTH 16

// fp16 lsb is 2^-24, plus 4 bits for the gaussian and 1 for halving
`define DFDD_FIX_WIDTH 50
`define DFDD_FIX_FRAC 28

`endif

//--- hw/fp16_pkg.sv
// fp16 word union with raw and field views
// signed fixed-point type
// exact fp16 to fixed conversion
// fixed to fp16 conversion with truncate, flush and saturate
`include "dfdd_cfg.svh"

package fp16_pkg;

    typedef union packed {
        logic [15:0] bits;
        struct packed {
            logic       sign;
            logic [4:0] exp;
            logic [9:0] frac;
        } f;
    } fp16_t;

    typedef logic signed [`DFDD_FIX_WIDTH-1:0] fix_t;

    // exponent 0 decodes as zero
    function automatic fix_t fp16_to_fix(fp16_t w);
        fix_t mag;
        mag = '0;
        if (w.f.exp != 5'd0) begin
            mag = fix_t'({1'b1, w.f.frac}) << (int'(w.f.exp) + `DFDD_FIX_FRAC - 25);
        end
        return w.f.sign ? -mag : mag;
    endfunction

    function automatic fp16_t fix_to_fp16(fix_t v);
        logic [`DFDD_FIX_WIDTH-1:0] mag;
        int msb;
        fp16_t w;
        mag = (v < 0) ? -v : v;
        msb = 0;
        w.bits = 16'h0000;
        for (int i = 0; i < `DFDD_FIX_WIDTH; i++) begin
            if (mag[i]) begin
                msb = i;
            end
        end
        // below 2^-14 stays +0
        if (msb >= `DFDD_FIX_FRAC - 14) begin
            w.f.sign = v[`DFDD_FIX_WIDTH-1];
            if (msb >= `DFDD_FIX_FRAC + 16) begin
                // clamp to 65504
                w.f.exp  = 5'd30;
                w.f.frac = 10'h3ff;
            end else begin
                w.f.exp  = 5'(msb - `DFDD_FIX_FRAC + 15);
                w.f.frac = 10'(mag >> (msb - 10));
            end
        end
        return w;
    endfunction

endpackage

//--- hw/stream_pkg.sv
// row state encoding
// pixel position type
`include "dfdd_cfg.svh"

package stream_pkg;

    typedef enum logic [1:0] {
        FILL,
        RUN,
        FLUSH1,
        FLUSH2
    } row_state_e;

    typedef logic [`DFDD_POS_WIDTH-1:0] pos_t;

endpackage

//--- hw/stream_if.sv
// win_ctrl_if: window controls and output position for the gaussian
// stage_if: filtered pixel pair between gaussian and combiner
`timescale 1ns/1ps

interface win_ctrl_if;
    import stream_pkg::*;

    logic load;
    logic shift;
    logic flush;
    logic emit;
    pos_t out_col;
    pos_t out_row;

    modport sequencer (output load, output shift, output flush, output emit);
    modport counter (input emit, output out_col, output out_row);
    modport filter (
        input load,
        input shift,
        input flush,
        input emit,
        input out_col,
        input out_row
    );
endinterface

interface stage_if;
    import fp16_pkg::*;
    import stream_pkg::*;

    fp16_t plus;
    fp16_t minus;
    pos_t  col;
    pos_t  row;
    logic  valid;

    modport source (output plus, output minus, output col, output row, output valid);
    modport sink (input plus, input minus, input col, input row, input valid);
endinterface

//--- hw/row_sequencer.sv
// per-row FSM: fill, run, two flush cycles
// drives the window load/shift/flush and emit controls
`timescale 1ns/1ps
`include "dfdd_cfg.svh"

module row_sequencer (
    input  logic                clk_i,
    input  logic                rst_i,
    input  logic                valid_i,
    input  stream_pkg::pos_t    col_i,
    win_ctrl_if.sequencer       ctrl
);
    import stream_pkg::*;

    row_state_e state_q;
    row_state_e state_d;

    always_comb begin
        state_d    = state_q;
        ctrl.load  = 1'b0;
        ctrl.shift = 1'b0;
        ctrl.flush = 1'b0;
        ctrl.emit  = 1'b0;
        case (state_q)
            FILL: begin
                if (valid_i) begin
                    if (col_i == '0) begin
                        ctrl.load = 1'b1;
                    end else begin
                        // column 1, window not yet centered
                        ctrl.shift = 1'b1;
                        state_d    = RUN;
                    end
                end
            end
            RUN: begin
                if (valid_i) begin
                    ctrl.shift = 1'b1;
                    ctrl.emit  = 1'b1;
                    if (col_i == pos_t'(`DFDD_IMAGE_WIDTH - 1)) begin
                        state_d = FLUSH1;
                    end
                end
            end
            FLUSH1: begin
                ctrl.flush = 1'b1;
                ctrl.emit  = 1'b1;
                state_d    = FLUSH2;
            end
            FLUSH2: begin
                ctrl.flush = 1'b1;
                ctrl.emit  = 1'b1;
                state_d    = FILL;
            end
            default: state_d = FILL;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= FILL;
        end else begin
            state_q <= state_d;
        end
    end

endmodule

//--- hw/position_counter.sv
// input column counter for the next sampled pixel
// output column/row counter for the next emitted center
`timescale 1ns/1ps
`include "dfdd_cfg.svh"

module position_counter (
    input  logic             clk_i,
    input  logic             rst_i,
    input  logic             valid_i,
    output stream_pkg::pos_t col_o,
    win_ctrl_if.counter      ctrl
);
    import stream_pkg::*;

    localparam pos_t LAST_COL = pos_t'(`DFDD_IMAGE_WIDTH - 1);
    localparam pos_t LAST_ROW = pos_t'(`DFDD_IMAGE_HEIGHT - 1);

    pos_t in_col_q;
    pos_t out_col_q;
    pos_t out_row_q;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            in_col_q <= '0;
        end else if (valid_i) begin
            in_col_q <= (in_col_q == LAST_COL) ? '0 : in_col_q + 1'b1;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            out_col_q <= '0;
            out_row_q <= '0;
        end else if (ctrl.emit) begin
            if (out_col_q == LAST_COL) begin
                out_col_q <= '0;
                out_row_q <= (out_row_q == LAST_ROW) ? '0 : out_row_q + 1'b1;
            end else begin
                out_col_q <= out_col_q + 1'b1;
            end
        end
    end

    assign col_o        = in_col_q;
    assign ctrl.out_col = out_col_q;
    assign ctrl.out_row = out_row_q;

endmodule

//--- hw/gauss_row_filter.sv
// 5-entry pixel windows for the plus and minus streams
// edge replication via load and flush
// exact (1,4,6,4,1)/16 weighting, one rounding to fp16
`timescale 1ns/1ps

module gauss_row_filter (
    input  logic            clk_i,
    input  logic            rst_i,
    input  fp16_pkg::fp16_t rho_plus_i,
    input  fp16_pkg::fp16_t rho_minus_i,
    win_ctrl_if.filter      ctrl,
    stage_if.source         out
);
    import fp16_pkg::*;
    import stream_pkg::*;

    // index 0 is rho plus, index 1 is rho minus
    fp16_t pix_w [2];
    fp16_t win_q [2][5];
    fix_t  sum_w [2];

    logic emit_q;
    pos_t col_q;
    pos_t row_q;

    assign pix_w[0] = rho_plus_i;
    assign pix_w[1] = rho_minus_i;

    ////////////////////////////////////////
    // windows

    always_ff @(posedge clk_i) begin
        for (int s = 0; s < 2; s++) begin
            if (ctrl.load) begin
                for (int k = 0; k < 5; k++) begin
                    win_q[s][k] <= pix_w[s];
                end
            end else if (ctrl.shift || ctrl.flush) begin
                for (int k = 0; k < 4; k++) begin
                    win_q[s][k] <= win_q[s][k+1];
                end
                // flush keeps the newest entry in place
                if (ctrl.shift) begin
                    win_q[s][4] <= pix_w[s];
                end
            end
        end
    end

    ////////////////////////////////////////
    // weighting, one cycle behind emit

    always_comb begin
        for (int s = 0; s < 2; s++) begin
            sum_w[s] = fp16_to_fix(win_q[s][0]) + fp16_to_fix(win_q[s][4])
                     + fix_t'(4) * (fp16_to_fix(win_q[s][1]) + fp16_to_fix(win_q[s][3]))
                     + fix_t'(6) * fp16_to_fix(win_q[s][2]);
        end
    end

    always_ff @(posedge clk_i) begin
        if (ctrl.emit) begin
            col_q <= ctrl.out_col;
            row_q <= ctrl.out_row;
        end
        if (emit_q) begin
            // sums are multiples of 16 lsb, so the shift is exact
            out.plus  <= fix_to_fp16(sum_w[0] >>> 4);
            out.minus <= fix_to_fp16(sum_w[1] >>> 4);
            out.col   <= col_q;
            out.row   <= row_q;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            emit_q    <= 1'b0;
            out.valid <= 1'b0;
        end else begin
            emit_q    <= ctrl.emit;
            out.valid <= emit_q;
        end
    end

endmodule

//--- hw/polarity_combiner.sv
// I_A = (plus + minus) / 2 and I_T = (plus - minus) / 2
// exact in fixed point, one rounding to fp16, registered outputs
`timescale 1ns/1ps

module polarity_combiner (
    input  logic             clk_i,
    input  logic             rst_i,
    stage_if.sink            in,
    output fp16_pkg::fp16_t  i_a_o,
    output fp16_pkg::fp16_t  i_t_o,
    output stream_pkg::pos_t col_o,
    output stream_pkg::pos_t row_o,
    output logic             valid_o
);
    import fp16_pkg::*;

    fp16_t neg_minus_w;
    fix_t  sum_w;
    fix_t  diff_w;

    always_comb begin
        // negate through the sign field
        neg_minus_w        = in.minus;
        neg_minus_w.f.sign = ~in.minus.f.sign;
        sum_w  = fp16_to_fix(in.plus) + fp16_to_fix(in.minus);
        diff_w = fp16_to_fix(in.plus) + fp16_to_fix(neg_minus_w);
    end

    always_ff @(posedge clk_i) begin
        if (in.valid) begin
            i_a_o <= fix_to_fp16(sum_w >>> 1);
            i_t_o <= fix_to_fp16(diff_w >>> 1);
            col_o <= in.col;
            row_o <= in.row;
        end
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_o <= 1'b0;
        end else begin
            valid_o <= in.valid;
        end
    end

endmodule

//--- hw/preproc_top.sv
// single-row fp16 preprocessing front end
// row FSM, position counters, gaussian windows, polarity combiner
`timescale 1ns/1ps

module preproc_top (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic [15:0] rho_plus_i,
    input  logic [15:0] rho_minus_i,
    output logic [15:0] i_a_o,
    output logic [15:0] i_t_o,
    output logic [15:0] col_o,
    output logic [15:0] row_o,
    output logic        valid_o
);
    import stream_pkg::*;

    pos_t in_col_w;

    win_ctrl_if ctrl_if ();
    stage_if    gauss_if ();

    row_sequencer u_sequencer (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .valid_i(valid_i),
        .col_i  (in_col_w),
        .ctrl   (ctrl_if)
    );

    position_counter u_position (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .valid_i(valid_i),
        .col_o  (in_col_w),
        .ctrl   (ctrl_if)
    );

    gauss_row_filter u_gauss (
        .clk_i      (clk_i),
        .rst_i      (rst_i),
        .rho_plus_i (rho_plus_i),
        .rho_minus_i(rho_minus_i),
        .ctrl       (ctrl_if),
        .out        (gauss_if)
    );

    polarity_combiner u_combiner (
        .clk_i  (clk_i),
        .rst_i  (rst_i),
        .in     (gauss_if),
        .i_a_o  (i_a_o),
        .i_t_o  (i_t_o),
        .col_o  (col_o),
        .row_o  (row_o),
        .valid_o(valid_o)
    );

endmodule

//--- test/preproc_props.sv
// concurrent checks on the row FSM controls
// bound into the row_sequencer instance
`timescale 1ns/1ps

module preproc_props (
    input logic                   clk_i,
    input logic                   rst_i,
    input logic                   valid_i,
    input stream_pkg::row_state_e state_i,
    input logic                   load_i,
    input logic                   shift_i,
    input logic                   flush_i,
    input logic                   emit_i
);
    import stream_pkg::*;

    int fail_count = 0;

    // input contract, two idle cycles after the last pixel
    no_valid_in_flush: assert property (@(posedge clk_i) disable iff (rst_i)
        (state_i == FLUSH1 || state_i == FLUSH2) |-> !valid_i)
    else begin
        fail_count++;
        $error("valid_i strobed during a flush cycle");
    end

    window_ops_onehot: assert property (@(posedge clk_i) disable iff (rst_i)
        $onehot0({load_i, shift_i, flush_i}))
    else begin
        fail_count++;
        $error("more than one of load, shift and flush high");
    end

    emit_with_update: assert property (@(posedge clk_i) disable iff (rst_i)
        emit_i |-> (shift_i || flush_i))
    else begin
        fail_count++;
        $error("emit high without shift or flush");
    end

endmodule

bind row_sequencer preproc_props u_props (
    .clk_i  (clk_i),
    .rst_i  (rst_i),
    .valid_i(valid_i),
    .state_i(state_q),
    .load_i (ctrl.load),
    .shift_i(ctrl.shift),
    .flush_i(ctrl.flush),
    .emit_i (ctrl.emit)
);

//--- test/preproc_checker.sv
// reference model of the front end in reals
// expected-output queues with due cycles
// in-order comparison and output count
`timescale 1ns/1ps
`include "dfdd_cfg.svh"

module preproc_checker (
    input  logic        clk_i,
    input  logic        rst_i,
    input  logic        valid_i,
    input  logic [15:0] rho_plus_i,
    input  logic [15:0] rho_minus_i,
    input  logic [15:0] ia_i,
    input  logic [15:0] it_i,
    input  logic [15:0] out_col_i,
    input  logic [15:0] out_row_i,
    input  logic        out_valid_i,
    output int          error_count_o,
    output int          check_count_o,
    output int          output_count_o
);
    localparam int W = `DFDD_IMAGE_WIDTH;
    localparam int H = `DFDD_IMAGE_HEIGHT;

    logic [15:0] plus_row [W];
    logic [15:0] minus_row [W];
    int in_col = 0;
    int in_row = 0;
    int cycle = 0;
    int errors = 0;
    int checks = 0;
    int outputs = 0;

    logic [15:0] exp_ia [$];
    logic [15:0] exp_it [$];
    int          exp_col [$];
    int          exp_row [$];
    int          exp_due [$];
    string       exp_name [$];

    assign error_count_o = errors;
    assign check_count_o = checks;

    ////////////////////////////////////////
    // fp16 number model

    function automatic real pow2(input int e);
        real r;
        r = 1.0;
        for (int i = 0; i < ((e < 0) ? -e : e); i++) begin
            r = (e < 0) ? r / 2.0 : r * 2.0;
        end
        return r;
    endfunction

    function automatic real to_real(input logic [15:0] w);
        real mag;
        if (w[14:10] == 5'd0) begin
            return 0.0;
        end
        mag = (1024.0 + $itor(w[9:0])) * pow2(int'(w[14:10]) - 25);
        return w[15] ? -mag : mag;
    endfunction

    // truncate toward zero, flush tiny values to +0, clamp at 65504
    function automatic logic [15:0] to_fp16(input real r);
        real  mag;
        logic sign;
        int   e;
        int   frac;
        mag  = (r < 0.0) ? -r : r;
        sign = (r < 0.0);
        if (mag < pow2(-14)) begin
            return 16'h0000;
        end
        if (mag >= 65504.0) begin
            return {sign, 15'h7bff};
        end
        e = 15;
        while (pow2(e) > mag) begin
            e--;
        end
        frac = $rtoi((mag / pow2(e) - 1.0) * 1024.0);
        return {sign, 5'(e + 15), 10'(frac)};
    endfunction

    // binomial 1,4,6,4,1 with the row edges replicated
    function automatic logic [15:0] gauss_at(input bit use_minus, input int center);
        int  idx;
        real sum;
        real weight [5];
        weight = '{1.0, 4.0, 6.0, 4.0, 1.0};
        sum = 0.0;
        for (int k = 0; k < 5; k++) begin
            idx = center + k - 2;
            idx = (idx < 0) ? 0 : ((idx > W - 1) ? W - 1 : idx);
            sum = sum + weight[k] * to_real(use_minus ? minus_row[idx] : plus_row[idx]);
        end
        return to_fp16(sum / 16.0);
    endfunction

    task automatic push_expected(input int center, input int due);
        real gp;
        real gm;
        gp = to_real(gauss_at(1'b0, center));
        gm = to_real(gauss_at(1'b1, center));
        exp_ia.push_back(to_fp16((gp + gm) / 2.0));
        exp_it.push_back(to_fp16((gp - gm) / 2.0));
        exp_col.push_back(center);
        exp_row.push_back(in_row);
        exp_due.push_back(due);
        if (plus_row[center] == minus_row[center]) begin
            exp_name.push_back("equal_pair");
        end else if (plus_row[center] == (minus_row[center] ^ 16'h8000)) begin
            exp_name.push_back("opposite_pair");
        end else if (center < 2 || center > W - 3) begin
            exp_name.push_back("border");
        end else begin
            exp_name.push_back("interior");
        end
    endtask

    ////////////////////////////////////////
    // comparison

    task automatic drop_front();
        void'(exp_ia.pop_front());
        void'(exp_it.pop_front());
        void'(exp_col.pop_front());
        void'(exp_row.pop_front());
        void'(exp_due.pop_front());
        void'(exp_name.pop_front());
    endtask

    task automatic check_value(input string name, input logic [15:0] expv,
                               input logic [15:0] actv);
        checks++;
        if (expv !== actv) begin
            errors++;
            $display("ERROR %s expected %h actual %h", name, expv, actv);
        end
    endtask

    task automatic compare_output();
        string tag;
        if (out_valid_i) begin
            outputs++;
            if (exp_due.size() == 0) begin
                errors++;
                $display("unexpected output at col %0d row %0d, nothing was pending",
                         out_col_i, out_row_i);
            end else begin
                if (exp_due[0] != cycle) begin
                    errors++;
                    $display("output for col %0d row %0d came at cycle %0d instead of %0d",
                             exp_col[0], exp_row[0], cycle, exp_due[0]);
                end
                tag = $sformatf("%s col %0d row %0d", exp_name[0], exp_col[0], exp_row[0]);
                check_value({tag, " col_o"}, 16'(exp_col[0]), out_col_i);
                check_value({tag, " row_o"}, 16'(exp_row[0]), out_row_i);
                check_value({tag, " i_a_o"}, exp_ia[0], ia_i);
                check_value({tag, " i_t_o"}, exp_it[0], it_i);
                drop_front();
            end
        end else if (exp_due.size() > 0 && exp_due[0] <= cycle) begin
            errors++;
            $display("missing output for col %0d row %0d", exp_col[0], exp_row[0]);
            drop_front();
        end
    endtask

    always @(posedge clk_i) begin
        cycle = cycle + 1;
        if (rst_i) begin
            in_col  = 0;
            in_row  = 0;
            outputs = 0;
            exp_due.delete();
            exp_ia.delete();
            exp_it.delete();
            exp_col.delete();
            exp_row.delete();
            exp_name.delete();
        end else begin
            compare_output();
            if (valid_i) begin
                plus_row[in_col]  = rho_plus_i;
                minus_row[in_col] = rho_minus_i;
                if (in_col >= 2) begin
                    push_expected(in_col - 2, cycle + 3);
                end
                if (in_col == W - 1) begin
                    // the two flush cycles complete the last two centers
                    push_expected(W - 2, cycle + 4);
                    push_expected(W - 1, cycle + 5);
                    in_col = 0;
                    in_row = (in_row == H - 1) ? 0 : in_row + 1;
                end else begin
                    in_col = in_col + 1;
                end
            end
        end
        output_count_o <= outputs;
    end

endmodule

//--- test/preproc_tb.sv
// testbench top with clock, reset and seeded random pixel rows
// DUT, reference checker, output timeout and closing result
`timescale 1ns/1ps
`include "dfdd_cfg.svh"

module preproc_tb;

    localparam int W           = `DFDD_IMAGE_WIDTH;
    localparam int NUM_ROWS    = 3 * `DFDD_IMAGE_HEIGHT;
    localparam int NUM_OUTPUTS = NUM_ROWS * W;
    localparam int DRAIN_LIMIT = 40;

    logic        clk = 1'b0;
    logic        rst;
    logic        valid;
    logic [15:0] rho_plus;
    logic [15:0] rho_minus;
    logic [15:0] i_a;
    logic [15:0] i_t;
    logic [15:0] col;
    logic [15:0] row;
    logic        valid_out;

    int          seed = 32'h46cd_e7bd;
    int          err_count;
    int          check_count;
    int          output_count;
    int          prop_fails;
    logic        timed_out;

    always #2 clk = ~clk;

    preproc_top u_dut (
        .clk_i      (clk),
        .rst_i      (rst),
        .valid_i    (valid),
        .rho_plus_i (rho_plus),
        .rho_minus_i(rho_minus),
        .i_a_o      (i_a),
        .i_t_o      (i_t),
        .col_o      (col),
        .row_o      (row),
        .valid_o    (valid_out)
    );

    preproc_checker u_checker (
        .clk_i         (clk),
        .rst_i         (rst),
        .valid_i       (valid),
        .rho_plus_i    (rho_plus),
        .rho_minus_i   (rho_minus),
        .ia_i          (i_a),
        .it_i          (i_t),
        .out_col_i     (col),
        .out_row_i     (row),
        .out_valid_i   (valid_out),
        .error_count_o (err_count),
        .check_count_o (check_count),
        .output_count_o(output_count)
    );

    // normal fp16 word with exponent 5 to 25 and either sign
    function automatic logic [15:0] random_word();
        logic       s;
        logic [4:0] e;
        logic [9:0] f;
        s = 1'($random(seed));
        e = 5'(5 + $unsigned($random(seed)) % 21);
        f = 10'($random(seed));
        return {s, e, f};
    endfunction

    initial begin
        int          gap;
        int          idle;
        logic [15:0] p;
        logic [15:0] m;
        rst       = 1'b1;
        valid     = 1'b0;
        rho_plus  = 16'h0000;
        rho_minus = 16'h0000;
        timed_out = 1'b1;
        repeat (3) @(posedge clk);
        rst <= 1'b0;

        for (int r = 0; r < NUM_ROWS; r++) begin
            for (int c = 0; c < W; c++) begin
                gap = $unsigned($random(seed)) % 4;
                repeat (gap) begin
                    @(posedge clk);
                    valid <= 1'b0;
                end
                p = random_word();
                // some rows carry equal or opposite pairs
                case (r % 4)
                    1: m = p;
                    3: m = p ^ 16'h8000;
                    default: m = random_word();
                endcase
                @(posedge clk);
                valid     <= 1'b1;
                rho_plus  <= p;
                rho_minus <= m;
            end
            idle = 2 + $unsigned($random(seed)) % 3;
            repeat (idle) begin
                @(posedge clk);
                valid <= 1'b0;
            end
        end

        // wait for the last outputs of the frame
        for (int i = 0; i < DRAIN_LIMIT; i++) begin
            @(posedge clk);
            if (output_count >= NUM_OUTPUTS) begin
                timed_out = 1'b0;
                break;
            end
        end
        if (timed_out) begin
            $display("timeout, only %0d of %0d outputs arrived", output_count, NUM_OUTPUTS);
        end

        prop_fails = u_dut.u_sequencer.u_props.fail_count;
        $display("checks %0d, value errors %0d, assertion failures %0d, timeouts %0d",
                 check_count, err_count, prop_fails, int'(timed_out));
        if (err_count == 0 && prop_fails == 0 && !timed_out) begin
            $display("Result: PASSED");
        end else begin
            $display("Result: FAILED");
        end
        $finish;
    end

endmodule

//--- src.f
+incdir+hw
hw/fp16_pkg.sv
hw/stream_pkg.sv
hw/stream_if.sv
hw/row_sequencer.sv
hw/position_counter.sv
hw/gauss_row_filter.sv
hw/polarity_combiner.sv
hw/preproc_top.sv
test/preproc_props.sv
test/preproc_checker.sv
test/preproc_tb.sv

//--- run.sh
#!/bin/sh
# build the preproc testbench with Verilator, run it and check the log

cd "$(dirname "$0")" || exit 1
rm -rf obj_dir

verilator --binary --assert -Wno-fatal -f src.f --top-module preproc_tb \
    -o preproc_sim > build.log 2>&1
if [ $? -ne 0 ]; then
    echo "build failed, see build.log"
    exit 1
fi

./obj_dir/preproc_sim +verilator+error+limit+1000 > sim.log 2>&1
status=$?
cat sim.log
if [ $status -ne 0 ]; then
    echo "simulation exited with status $status"
    exit 1
fi

if grep -q "^Result: PASSED$" sim.log; then
    exit 0
fi
exit 1
